/* Makefile */
TOP = tb_f2_cpu_bus

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* address_decoder.sv */
`timescale 1ns/10ps

module address_decoder import f2_pkg::*; (
    input        [ADDR_W-1:0] cpu_addr,
    input               [2:0] cpu_fc,

    input        [PAGE_W-1:0] rom_page,
    input        [PAGE_W-1:0] work_page,
    input        [PAGE_W-1:0] io_page,

    output region_t           region
);

logic [PAGE_W-1:0] page;
logic              iack;

// Byte address bits 23..16
assign page = cpu_addr[ADDR_W-1 -: PAGE_W];

// Interrupt acknowledge space ignores the address
assign iack = &cpu_fc;

always_comb begin
    region = REGION_NONE;

    if (iack) begin
        region = REGION_IACK;
    end else if (page == rom_page) begin
        region = REGION_ROM;
    end else if (page == work_page) begin
        region = REGION_WORK;
    end else if (page == io_page) begin
        region = REGION_IO;
    end
end

endmodule

/* board_config.sv */
`timescale 1ns/10ps

module board_config import f2_pkg::*; (
    input                     clk,
    input                     reset,

    input  game_t             game,

    output logic [PAGE_W-1:0] rom_page,
    output logic [PAGE_W-1:0] work_page,
    output logic [PAGE_W-1:0] io_page,
    output logic              io_swap
);

game_t      game_q; // Game the current entry belongs to
board_cfg_t entry;

assign entry = BOARD_TABLE[game];

// Reload whenever the selection moves, and always during reset
always_ff @(posedge clk) begin
    if (reset || game != game_q) begin
        game_q    <= game;
        rom_page  <= entry.rom_page;
        work_page <= entry.work_page;
        io_page   <= entry.io_page;
        io_swap   <= entry.io_swap;
    end
end

endmodule

/* build.f */
f2_pkg.sv
board_config.sv
address_decoder.sv
work_ram.sv
input_ports.sv
irq_controller.sv
bus_read_mux.sv
f2_cpu_bus.sv
f2_cpu_bus_asserts.sv
tb_f2_cpu_bus.sv

/* bus_read_mux.sv */
`timescale 1ns/10ps

module bus_read_mux import f2_pkg::*; (
    input                     clk,
    input                     reset,

    input  region_t           region,
    input                     cpu_as_n,

    input        [DATA_W-1:0] rom_q,
    input        [DATA_W-1:0] work_q,
    input               [7:0] io_q,
    input                     rom_dtack_n,

    output logic [DATA_W-1:0] cpu_data_in,
    output logic              dtack_n,
    output logic              rom_cs_n
);

logic as_seen; // Strobe low for one edge
logic as_held; // Strobe low for two edges
logic local_dtack_n;
logic rom_sel;

assign rom_sel = (region == REGION_ROM);

////////////////////////////////////////////////////////////
// Fixed two cycle acknowledge

always_ff @(posedge clk) begin
    if (reset) begin
        as_seen <= 1'b0;
        as_held <= 1'b0;
    end else begin
        as_seen <= ~cpu_as_n;
        as_held <= as_seen & ~cpu_as_n;
    end
end

assign local_dtack_n = ~as_held;

// ROM cycles wait on the external acknowledge
assign dtack_n  = cpu_as_n | (rom_sel ? rom_dtack_n : local_dtack_n);
assign rom_cs_n = ~(rom_sel & ~cpu_as_n);

////////////////////////////////////////////////////////////
// Read data

always_comb begin
    case (region)
        REGION_ROM:  cpu_data_in = rom_q;
        REGION_WORK: cpu_data_in = work_q;
        REGION_IO:   cpu_data_in = {io_q, io_q}; // 8 bit chip on both lanes
        default:     cpu_data_in = '0; // Unmapped and autovectored IACK
    endcase
end

endmodule

/* f2_cpu_bus.sv */
`timescale 1ns/10ps

module f2_cpu_bus import f2_pkg::*; #(
    parameter int WORK_ADDR_BITS = 12
) (
    input                     clk,
    input                     reset,

    input  game_t             game,

    // 68000 side
    input        [ADDR_W-1:0] cpu_addr,
    input        [DATA_W-1:0] cpu_data_out,
    input                     cpu_rw,
    input                     cpu_as_n,
    input               [1:0] cpu_ds_n,
    input               [2:0] cpu_fc,
    output       [DATA_W-1:0] cpu_data_in,
    output                    dtack_n,
    output              [2:0] ipl_n,

    // Program ROM outside the block
    input        [DATA_W-1:0] rom_q,
    input                     rom_dtack_n,
    output                    rom_cs_n,

    input                     vblank_n,
    input                     dma_n,

    input               [9:0] joystick_p1,
    input               [9:0] joystick_p2,
    input               [1:0] start,
    input               [1:0] coin,
    input               [7:0] dswa,
    input               [7:0] dswb
);

wire [PAGE_W-1:0] rom_page;
wire [PAGE_W-1:0] work_page;
wire [PAGE_W-1:0] io_page;
wire              io_swap;

region_t          region;

wire [DATA_W-1:0] work_q;
wire        [7:0] io_q;
wire              work_wr;
wire        [1:0] work_we_n;

////////////////////////////////////////////////////////////
// Memory map

board_config board_config (
    .clk,
    .reset,
    .game,
    .rom_page,
    .work_page,
    .io_page,
    .io_swap
);

address_decoder address_decoder (
    .cpu_addr,
    .cpu_fc,
    .rom_page,
    .work_page,
    .io_page,
    .region
);

////////////////////////////////////////////////////////////
// Devices

assign work_wr   = (region == REGION_WORK) & ~cpu_rw;
assign work_we_n = cpu_ds_n | {2{~work_wr}}; // Per lane strobes

work_ram #(.ADDR_BITS(WORK_ADDR_BITS)) work_ram (
    .clk,
    .addr(cpu_addr[WORK_ADDR_BITS-1:0]),
    .we_n(work_we_n),
    .din(cpu_data_out),
    .q(work_q)
);

input_ports input_ports (
    .clk,
    .offset(cpu_addr[IO_OFFSET_W-1:0]),
    .io_swap,
    .joystick_p1,
    .joystick_p2,
    .start,
    .coin,
    .dswa,
    .dswb,
    .q(io_q)
);

irq_controller irq_controller (
    .clk,
    .reset,
    .vblank_n,
    .dma_n,
    .region,
    .cpu_as_n,
    .cpu_addr,
    .ipl_n
);

bus_read_mux bus_read_mux (
    .clk,
    .reset,
    .region,
    .cpu_as_n,
    .rom_q,
    .work_q,
    .io_q,
    .rom_dtack_n,
    .cpu_data_in,
    .dtack_n,
    .rom_cs_n
);

endmodule

/* f2_cpu_bus_asserts.sv */
`timescale 1ns/10ps

module f2_cpu_bus_asserts import f2_pkg::*; (
    input       clk,
    input       reset,
    input       cpu_as_n,
    input       dtack_n,
    input [2:0] ipl_n,
    input       req_vbl,
    input       req_dma,
    input       clr_vbl,
    input       clr_dma
);

// No acknowledge in the first cycle of a strobe
dtack_idle: assert property (@(posedge clk) disable iff (reset)
    $past(cpu_as_n) |-> dtack_n)
    else $error("dtack_n low after an idle bus cycle");

// Only levels 0, 5 and 6 exist on this board
ipl_legal: assert property (@(posedge clk) disable iff (reset)
    ipl_n == 3'b111 || ipl_n == ~IRQ_LEVEL_VBL || ipl_n == ~IRQ_LEVEL_DMA)
    else $error("ipl_n shows level %0d", ~ipl_n);

vbl_held: assert property (@(posedge clk) disable iff (reset) req_vbl && !clr_vbl |=> req_vbl)
    else $error("VBL request dropped without acknowledge");

dma_held: assert property (@(posedge clk) disable iff (reset) req_dma && !clr_dma |=> req_dma)
    else $error("DMA request dropped without acknowledge");

endmodule

bind irq_controller f2_cpu_bus_asserts irq_asserts (
    .clk, .reset, .cpu_as_n, .dtack_n(1'b1), .ipl_n,
    .req_vbl, .req_dma, .clr_vbl, .clr_dma);

bind bus_read_mux f2_cpu_bus_asserts bus_asserts (
    .clk, .reset, .cpu_as_n, .dtack_n, .ipl_n(3'b111),
    .req_vbl(1'b0), .req_dma(1'b0), .clr_vbl(1'b0), .clr_dma(1'b0));

/* f2_pkg.sv */
package f2_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths

    localparam int ADDR_W = 23; // Word address, byte bit implied
    localparam int DATA_W = 16;
    localparam int PAGE_W = 8; // Upper bits of the byte address
    localparam int IO_OFFSET_W = 3;

    ////////////////////////////////////////////////////////////
    // Interrupt levels

    localparam logic [2:0] IRQ_LEVEL_VBL = 3'd5;
    localparam logic [2:0] IRQ_LEVEL_DMA = 3'd6;

    ////////////////////////////////////////////////////////////
    // Boards and regions

    typedef enum logic [1:0] {
        GAME_FINALB   = 2'd0,
        GAME_DONDOKOD = 2'd1,
        GAME_MEGAB    = 2'd2,
        GAME_THUNDFOX = 2'd3
    } game_t;

    typedef enum logic [2:0] {
        REGION_NONE = 3'd0,
        REGION_ROM  = 3'd1,
        REGION_WORK = 3'd2,
        REGION_IO   = 3'd3,
        REGION_IACK = 3'd4
    } region_t;

    typedef struct packed {
        logic [PAGE_W-1:0] rom_page;
        logic [PAGE_W-1:0] work_page;
        logic [PAGE_W-1:0] io_page;
        logic              io_swap;
    } board_cfg_t;

    // One 64 KB page per region, indexed by game_t
    localparam board_cfg_t BOARD_TABLE [4] = '{
        '{rom_page: 8'h00, work_page: 8'h10, io_page: 8'h30, io_swap: 1'b0}, // Final Blow
        '{rom_page: 8'h00, work_page: 8'h10, io_page: 8'h30, io_swap: 1'b1}, // Don Doko Don
        '{rom_page: 8'h00, work_page: 8'h20, io_page: 8'h12, io_swap: 1'b0}, // Mega Blast
        '{rom_page: 8'h00, work_page: 8'h30, io_page: 8'h22, io_swap: 1'b1}  // Thunder Fox
    };

endpackage

/* f2_stim.txt */
# g game | p p1 p2 start coin dswa dswb | w byte_addr ds_n data | r byte_addr region data
# v level | d level | a level level_after ; all fields hex, level 0 means none pending
g 0
w 100010 0 1234
r 100010 2 1234
w 100010 1 ab99
r 100010 2 ab34
p 3f5 0a6 1 2 a5 3c
r 300000 3 5a5a
r 300002 3 c3c3
r 300004 3 0505
r 300006 3 d9d9
r 300008 3 e7e7
r 30000a 3 ffff
r 500000 0 0000
r 000100 1 807f
g 1
w 100020 0 5678
w 100020 1 cd00
r 100020 2 cd78
r 300000 3 c3c3
r 300002 3 5a5a
g 2
w 200030 0 9abc
w 200030 1 ef11
r 200030 2 efbc
r 120004 3 0505
r 100000 0 0000
g 3
w 300040 0 4321
w 300040 1 7700
r 300040 2 7721
r 220002 3 5a5a
v 5
d 6
a 6 5
a 5 0

/* input_ports.sv */
`timescale 1ns/10ps

module input_ports import f2_pkg::*; (
    input                        clk,

    input      [IO_OFFSET_W-1:0] offset,
    input                        io_swap,

    input                  [9:0] joystick_p1,
    input                  [9:0] joystick_p2,
    input                  [1:0] start,
    input                  [1:0] coin,
    input                  [7:0] dswa,
    input                  [7:0] dswb,

    output logic           [7:0] q
);

logic [IO_OFFSET_W-1:0] sel;
logic             [7:0] p1_byte;
logic             [7:0] p2_byte;
logic             [7:0] sys_byte;
logic             [7:0] port_byte;

// Some boards wire the low address line inverted
assign sel = io_swap ? {offset[IO_OFFSET_W-1:1], ~offset[0]} : offset;

// Start, buttons, then directions in reverse order
assign p1_byte = {start[0], joystick_p1[6:4],
                  joystick_p1[0], joystick_p1[1], joystick_p1[2], joystick_p1[3]};
assign p2_byte = {start[1], joystick_p2[6:4],
                  joystick_p2[0], joystick_p2[1], joystick_p2[2], joystick_p2[3]};

assign sys_byte = {2'b00, start[1:0], coin[1:0], 2'b00};

always_comb begin
    case (sel)
        3'd0:    port_byte = dswa;
        3'd1:    port_byte = dswb;
        3'd2:    port_byte = p1_byte;
        3'd3:    port_byte = p2_byte;
        3'd4:    port_byte = sys_byte;
        default: port_byte = 8'h00; // Unused, reads 0xFF
    endcase
end

// Board inputs are active low
always_ff @(posedge clk) begin
    q <= ~port_byte;
end

endmodule

/* irq_controller.sv */
`timescale 1ns/10ps

module irq_controller import f2_pkg::*; (
    input                     clk,
    input                     reset,

    input                     vblank_n,
    input                     dma_n,

    input  region_t           region,
    input                     cpu_as_n,
    input        [ADDR_W-1:0] cpu_addr,

    output logic        [2:0] ipl_n
);

logic vbl_prev;
logic dma_prev;
logic req_vbl;
logic req_dma;
logic ack_cycle;
logic clr_vbl;
logic clr_dma;

assign ack_cycle = (region == REGION_IACK) & ~cpu_as_n;
assign clr_vbl   = ack_cycle & (cpu_addr[2:0] == IRQ_LEVEL_VBL);
assign clr_dma   = ack_cycle & (cpu_addr[2:0] == IRQ_LEVEL_DMA);

always_ff @(posedge clk) begin
    if (reset) begin
        vbl_prev <= 1'b0; // No false edge out of reset
        dma_prev <= 1'b1;
        req_vbl  <= 1'b0;
        req_dma  <= 1'b0;
    end else begin
        vbl_prev <= vblank_n;
        dma_prev <= dma_n;

        if (vbl_prev & ~vblank_n) begin // Start of vblank
            req_vbl <= 1'b1;
        end
        if (~dma_prev & dma_n) begin // Object DMA done
            req_dma <= 1'b1;
        end

        // Acknowledge beats a new edge
        if (clr_vbl) begin
            req_vbl <= 1'b0;
        end
        if (clr_dma) begin
            req_dma <= 1'b0;
        end
    end
end

////////////////////////////////////////////////////////////
// Priority, DMA above VBL

always_comb begin
    if (req_dma) begin
        ipl_n = ~IRQ_LEVEL_DMA;
    end else if (req_vbl) begin
        ipl_n = ~IRQ_LEVEL_VBL;
    end else begin
        ipl_n = 3'b111;
    end
end

endmodule

/* tb_f2_cpu_bus.sv */
`timescale 1ns/10ps

module tb_f2_cpu_bus import f2_pkg::*; ();

logic              clk;
logic              reset;
game_t             game;
logic [ADDR_W-1:0] cpu_addr;
logic [DATA_W-1:0] cpu_data_out, cpu_data_in, rom_q;
logic              cpu_rw, cpu_as_n, dtack_n, rom_cs_n, vblank_n, dma_n;
logic        [1:0] cpu_ds_n, start, coin;
logic        [2:0] cpu_fc, ipl_n;
logic        [9:0] joystick_p1, joystick_p2;
logic        [7:0] dswa, dswb;
logic              rom_dtack_n = 1'b1;
logic        [7:0] rom_wait = 8'd0;

logic [DATA_W-1:0] ram_model [4096]; // Expected work RAM contents
logic       [11:0] rnd_addr [16];
logic [DATA_W-1:0] rdata;
region_t           rgn;
logic       [31:0] f1, f2, f3, f4, f5, f6, seed;
logic        [7:0] ch;
int                errors, checks, cycles, limit, fd, c, n;

f2_cpu_bus #(.WORK_ADDR_BITS(12)) uut (.*);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

// ROM outside the block, acknowledges three cycles into a cycle
assign rom_q = {cpu_addr[7:0], ~cpu_addr[7:0]};
always @(posedge clk) rom_wait <= rom_cs_n ? 8'd0 : rom_wait + 8'd1;
always @(negedge clk) rom_dtack_n <= (rom_wait < 8'd3);

////////////////////////////////////////////////////////////
// Compare tasks

task automatic check_data(input logic [DATA_W-1:0] got, exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error at %0t: %s gave 0x%h, expected 0x%h", $time, what, got, exp);
    end
endtask

task automatic check_ipl(input logic [2:0] got, exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error at %0t: ipl_n is %b, expected %b", $time, got, exp);
    end
endtask

task automatic check_region(input region_t got, exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error at %0t: region %s, expected %s", $time, got.name(), exp.name());
    end
endtask

task automatic check_strobe(input logic got, exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

////////////////////////////////////////////////////////////
// Bus cycles

task automatic bus_cycle(input logic [23:0] byte_addr, input logic rw, input logic [1:0] ds_n,
                         input logic [2:0] fc, input logic [DATA_W-1:0] wdata);
    int waits;
    waits = 0;
    cpu_addr = byte_addr[23:1];
    cpu_rw = rw;
    cpu_ds_n = ds_n;
    cpu_fc = fc;
    cpu_data_out = wdata;
    cpu_as_n = 1'b0;
    while (dtack_n) begin
        @(negedge clk);
        waits++;
    end
    rdata = cpu_data_in;
    rgn = uut.region;
    if (rgn == REGION_ROM) begin
        check_strobe(rom_cs_n, 1'b0, "rom_cs_n");
        check_strobe(rom_dtack_n, 1'b0, "rom_dtack_n"); // DTACK belongs to the ROM
    end else begin
        checks++;
        if (waits != 2) begin
            errors++;
            $display("Error at %0t: DTACK after %0d cycles, expected 2", $time, waits);
        end
    end
    cpu_as_n = 1'b1;
    cpu_ds_n = 2'b11;
    cpu_rw = 1'b1;
    cpu_fc = 3'b101; // Supervisor data
    @(negedge clk);
endtask

task automatic pulse_irq(input logic vbl);
    if (vbl) begin
        vblank_n = 1'b0;
    end else begin
        dma_n = 1'b0;
    end
    repeat (2) @(negedge clk);
    vblank_n = 1'b1;
    dma_n = 1'b1;
    repeat (2) @(negedge clk);
endtask

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

initial begin
    reset = 1'b1;
    game = GAME_FINALB;
    cpu_addr = '0;
    cpu_data_out = '0;
    cpu_rw = 1'b1;
    cpu_as_n = 1'b1;
    cpu_ds_n = 2'b11;
    cpu_fc = 3'b101;
    vblank_n = 1'b1;
    dma_n = 1'b1;
    joystick_p1 = '0;
    joystick_p2 = '0;
    start = '0;
    coin = '0;
    dswa = '0;
    dswb = '0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    check_strobe(dtack_n, 1'b1, "dtack_n");
    check_ipl(ipl_n, 3'b111);
    check_strobe(rom_cs_n, 1'b1, "rom_cs_n");

    fd = $fopen("f2_stim.txt", "r");
    if (fd == 0) begin
        errors++;
        $display("Could not open f2_stim.txt");
    end else begin
        c = $fgetc(fd);
        while (c != -1) begin // 40 cycles per line
            if (c == 10) limit += 40;
            c = $fgetc(fd);
        end
        limit += 2000;
        $fclose(fd);
        fd = $fopen("f2_stim.txt", "r");
        c = $fgetc(fd);
        while (c != -1) begin
            ch = c[7:0];
            case (ch)
                "#": begin
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end
                "g": begin
                    n = $fscanf(fd, " %h", f1);
                    game = game_t'(f1[1:0]);
                    repeat (2) @(negedge clk);
                end
                "p": begin
                    n = $fscanf(fd, " %h %h %h %h %h %h", f1, f2, f3, f4, f5, f6);
                    joystick_p1 = f1[9:0];
                    joystick_p2 = f2[9:0];
                    start = f3[1:0];
                    coin = f4[1:0];
                    dswa = f5[7:0];
                    dswb = f6[7:0];
                    @(negedge clk);
                end
                "w": begin
                    n = $fscanf(fd, " %h %h %h", f1, f2, f3);
                    bus_cycle(f1[23:0], 1'b0, f2[1:0], 3'b101, f3[15:0]);
                end
                "r": begin
                    n = $fscanf(fd, " %h %h %h", f1, f2, f3);
                    bus_cycle(f1[23:0], 1'b1, 2'b00, 3'b101, 16'h0000);
                    check_region(rgn, region_t'(f2[2:0]));
                    check_data(rdata, f3[15:0], "read");
                end
                "v", "d": begin
                    n = $fscanf(fd, " %h", f1);
                    pulse_irq(ch == "v");
                    check_ipl(ipl_n, ~f1[2:0]);
                end
                "a": begin // Level sits on address bits 3..1
                    n = $fscanf(fd, " %h %h", f1, f2);
                    bus_cycle({20'h00000, f1[2:0], 1'b0}, 1'b1, 2'b00, 3'b111, 16'h0000);
                    check_ipl(ipl_n, ~f2[2:0]);
                end
                default: ;
            endcase
            c = $fgetc(fd);
        end
        $fclose(fd);

        // Random fill of the Mega Blast work page
        game = GAME_MEGAB;
        repeat (2) @(negedge clk);
        seed = 32'h98b;
        for (int i = 0; i < 16; i++) begin
            seed = lcg_next(seed);
            rnd_addr[i] = seed[11:0];
            ram_model[seed[11:0]] = seed[31:16];
            bus_cycle({8'h20, 3'b000, seed[11:0], 1'b0}, 1'b0, 2'b00, 3'b101, seed[31:16]);
        end
        for (int i = 0; i < 16; i++) begin
            bus_cycle({8'h20, 3'b000, rnd_addr[i], 1'b0}, 1'b1, 2'b00, 3'b101, 16'h0000);
            check_data(rdata, ram_model[rnd_addr[i]], "work RAM");
        end
    end

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
        $display("Verification passed");
    end else begin
        $display("Verification failed");
    end
    $finish;
end

initial begin
    wait (limit != 0);
    while (cycles < limit) begin
        @(posedge clk);
        cycles++;
    end
    $display("Timeout after %0d cycles, a bus cycle never finished", cycles);
    $display("Verification failed");
    $finish;
end

endmodule

/* work_ram.sv */
`timescale 1ns/10ps

module work_ram import f2_pkg::*; #(
    parameter int ADDR_BITS = 12
) (
    input                        clk,

    input        [ADDR_BITS-1:0] addr,
    input                  [1:0] we_n, // Bit 1 is the upper byte
    input           [DATA_W-1:0] din,
    output logic    [DATA_W-1:0] q
);

logic [DATA_W-1:0] mem [2**ADDR_BITS];

always_ff @(posedge clk) begin
    if (~we_n[1]) begin
        mem[addr][15:8] <= din[15:8];
    end
    if (~we_n[0]) begin
        mem[addr][7:0] <= din[7:0];
    end

    q <= mem[addr]; // Old data on a write cycle
end

endmodule
